// ==== common/instr_cfg.svh ====
`ifndef INSTR_CFG_SVH
`define INSTR_CFG_SVH

// ============================================================
// widths
// ============================================================
`define INSTR_BYTE_W       8
`define INSTR_DUTY_W       8
`define INSTR_DAC_W        14

// channel counts
`define INSTR_PWM_CH       8
`define INSTR_DAC_CH       2

// ============================================================
// frame bytes and opcodes
// ============================================================
`define INSTR_SYNC_BYTE    8'h55
`define INSTR_REPLY_BYTE   8'h5A

`define INSTR_OP_SET_DUTY  8'h01
`define INSTR_OP_SET_DAC   8'h02
`define INSTR_OP_READ_DUTY 8'h03

`endif

// ==== common/instr_pkg.sv ====
`include "instr_cfg.svh"

package instr_pkg;

    // one byte of the usb stream
    typedef logic [`INSTR_BYTE_W-1:0] instr_byte_t;

    // duty value and period count
    typedef logic [`INSTR_DUTY_W-1:0] duty_t;

    // pwm channel index and pin vector
    typedef logic [$clog2(`INSTR_PWM_CH)-1:0] pwm_ch_t;
    typedef logic [`INSTR_PWM_CH-1:0] pwm_vec_t;

    // two's complement inside and offset binary on the pins
    typedef logic signed [`INSTR_DAC_W-1:0] dac_code_t;

    // ============================================================
    // command parser states
    // ============================================================
    typedef enum logic [3:0] {
        // frame assembly
        ST_IDLE,
        ST_OPCODE,
        ST_INDEX,
        ST_DATA_HI,
        ST_DATA_LO,
        // dispatch
        ST_EXEC,
        // reply burst
        ST_REPLY_HDR,
        ST_REPLY_IDX,
        ST_REPLY_VAL
    } parser_state_t;

endpackage

// ==== cmd_parser/cmd_parser_fsm.sv ====
`include "instr_cfg.svh"

module cmd_parser_fsm
    import instr_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,

    // byte stream from the usb endpoint
    input  instr_byte_t usb_data_i,
    input  logic        usb_valid_i,

    // pwm bank write and read-back
    output logic        duty_we_o,
    output pwm_ch_t     duty_ch_o,
    output duty_t       duty_wdata_o,
    output pwm_ch_t     rd_ch_o,
    input  duty_t       rd_duty_i,

    // dac driver write
    output logic        dac_we_a_o,
    output logic        dac_we_b_o,
    output dac_code_t   dac_wdata_o,

    // reply bytes back to the host
    output instr_byte_t usb_upload_data_o,
    output logic        usb_upload_valid_o
);

    parser_state_t state_q;
    parser_state_t state_d;

    // latched frame fields
    instr_byte_t opcode_q;
    instr_byte_t index_q;
    instr_byte_t data_hi_q;
    instr_byte_t data_lo_q;

    logic        pwm_idx_ok;
    logic        dac_idx_ok;
    logic        in_exec;

    logic        duty_we_q;
    logic        dac_we_a_q;
    logic        dac_we_b_q;
    instr_byte_t upload_data_q;
    logic        upload_valid_q;

    assign pwm_idx_ok = (index_q < `INSTR_PWM_CH);
    assign dac_idx_ok = (index_q < `INSTR_DAC_CH);
    assign in_exec    = (state_q == ST_EXEC);

    // ============================================================
    // state machine
    // ============================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // anything but sync is ignored here
                if (usb_valid_i && (usb_data_i == `INSTR_SYNC_BYTE)) begin
                    state_d = ST_OPCODE;
                end
            end
            ST_OPCODE: begin
                if (usb_valid_i) begin
                    state_d = ST_INDEX;
                end
            end
            ST_INDEX: begin
                if (usb_valid_i) begin
                    state_d = ST_DATA_HI;
                end
            end
            ST_DATA_HI: begin
                if (usb_valid_i) begin
                    state_d = ST_DATA_LO;
                end
            end
            ST_DATA_LO: begin
                if (usb_valid_i) begin
                    state_d = ST_EXEC;
                end
            end
            ST_EXEC: begin
                if ((opcode_q == `INSTR_OP_READ_DUTY) && pwm_idx_ok) begin
                    state_d = ST_REPLY_HDR;
                end else begin
                    state_d = ST_IDLE;
                end
            end
            // input bytes are dropped during the reply
            ST_REPLY_HDR: state_d = ST_REPLY_IDX;
            ST_REPLY_IDX: state_d = ST_REPLY_VAL;
            ST_REPLY_VAL: state_d = ST_IDLE;
            default:      state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // frame field capture
    always_ff @(posedge clk_i) begin
        if (usb_valid_i) begin
            case (state_q)
                ST_OPCODE:  opcode_q  <= usb_data_i;
                ST_INDEX:   index_q   <= usb_data_i;
                ST_DATA_HI: data_hi_q <= usb_data_i;
                ST_DATA_LO: data_lo_q <= usb_data_i;
                default:    ;
            endcase
        end
    end

    // ============================================================
    // write strobes one cycle after exec
    // ============================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            duty_we_q  <= 1'b0;
            dac_we_a_q <= 1'b0;
            dac_we_b_q <= 1'b0;
        end else begin
            duty_we_q  <= in_exec && (opcode_q == `INSTR_OP_SET_DUTY) && pwm_idx_ok;
            dac_we_a_q <= in_exec && (opcode_q == `INSTR_OP_SET_DAC) && dac_idx_ok
                          && !index_q[0];
            dac_we_b_q <= in_exec && (opcode_q == `INSTR_OP_SET_DAC) && dac_idx_ok
                          && index_q[0];
        end
    end

    // ============================================================
    // reply burst of header, index and duty
    // ============================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            upload_data_q  <= '0;
            upload_valid_q <= 1'b0;
        end else begin
            upload_valid_q <= 1'b0;
            case (state_q)
                ST_REPLY_HDR: begin
                    upload_data_q  <= `INSTR_REPLY_BYTE;
                    upload_valid_q <= 1'b1;
                end
                ST_REPLY_IDX: begin
                    upload_data_q  <= index_q;
                    upload_valid_q <= 1'b1;
                end
                ST_REPLY_VAL: begin
                    // active duty of the latched channel
                    upload_data_q  <= rd_duty_i;
                    upload_valid_q <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign duty_we_o          = duty_we_q;
    assign duty_ch_o          = index_q[$bits(pwm_ch_t)-1:0];
    assign duty_wdata_o       = data_lo_q;
    assign rd_ch_o            = index_q[$bits(pwm_ch_t)-1:0];

    // 14-bit code is data_hi[5:0] then data_lo
    assign dac_we_a_o         = dac_we_a_q;
    assign dac_we_b_o         = dac_we_b_q;
    assign dac_wdata_o        = {data_hi_q[`INSTR_DAC_W-`INSTR_BYTE_W-1:0], data_lo_q};

    assign usb_upload_data_o  = upload_data_q;
    assign usb_upload_valid_o = upload_valid_q;

endmodule

// ==== verilog/pwm_timebase.sv ====
`include "instr_cfg.svh"

module pwm_timebase
    import instr_pkg::*;
(
    input  logic  clk_i,
    input  logic  arst_n_i,

    output duty_t pwm_cnt_o,
    output logic  pwm_wrap_o
);

    duty_t cnt_q;
    logic  wrap_q;

    // ============================================================
    // free-running period counter
    // ============================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '0;
            wrap_q <= 1'b0;
        end else begin
            cnt_q  <= cnt_q + 1'b1;
            // high exactly while the count reads 0
            wrap_q <= (cnt_q == {`INSTR_DUTY_W{1'b1}});
        end
    end

    assign pwm_cnt_o  = cnt_q;
    assign pwm_wrap_o = wrap_q;

endmodule

// ==== verilog/pwm_bank.sv ====
`include "instr_cfg.svh"

module pwm_bank
    import instr_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,

    // writes from the parser
    input  logic     duty_we_i,
    input  pwm_ch_t  duty_ch_i,
    input  duty_t    duty_wdata_i,

    // read-back select
    input  pwm_ch_t  rd_ch_i,

    // timebase
    input  duty_t    pwm_cnt_i,
    input  logic     pwm_wrap_i,

    output pwm_vec_t pwm_o,
    output duty_t    rd_duty_o
);

    duty_t    shadow_q [`INSTR_PWM_CH];
    duty_t    active_q [`INSTR_PWM_CH];
    pwm_vec_t pwm_q;

    // ============================================================
    // shadow and active duty registers
    // ============================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `INSTR_PWM_CH; i++) begin
                shadow_q[i] <= '0;
                active_q[i] <= '0;
            end
        end else begin
            if (duty_we_i) begin
                shadow_q[duty_ch_i] <= duty_wdata_i;
            end
            // all channels switch together at the period boundary
            if (pwm_wrap_i) begin
                for (int i = 0; i < `INSTR_PWM_CH; i++) begin
                    active_q[i] <= shadow_q[i];
                end
            end
        end
    end

    // pin is high while count is below duty
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pwm_q <= '0;
        end else begin
            for (int i = 0; i < `INSTR_PWM_CH; i++) begin
                pwm_q[i] <= (pwm_cnt_i < active_q[i]);
            end
        end
    end

    assign pwm_o     = pwm_q;
    assign rd_duty_o = active_q[rd_ch_i];

endmodule

// ==== verilog/dac_driver.sv ====
`include "instr_cfg.svh"

module dac_driver
    import instr_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  logic      dac_we_a_i,
    input  logic      dac_we_b_i,
    input  dac_code_t dac_wdata_i,

    // offset binary towards the converter
    output dac_code_t dac_data_a_o,
    output dac_code_t dac_data_b_o
);

    // signed zero in offset binary
    localparam dac_code_t MIDSCALE = dac_code_t'(1 << (`INSTR_DAC_W - 1));

    dac_code_t data_a_q;
    dac_code_t data_b_q;

    // flip the sign bit
    function automatic dac_code_t to_offset_bin(input dac_code_t code);
        return {~code[`INSTR_DAC_W-1], code[`INSTR_DAC_W-2:0]};
    endfunction

    // ============================================================
    // channel registers
    // ============================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_a_q <= MIDSCALE;
            data_b_q <= MIDSCALE;
        end else begin
            if (dac_we_a_i) begin
                data_a_q <= to_offset_bin(dac_wdata_i);
            end
            if (dac_we_b_i) begin
                data_b_q <= to_offset_bin(dac_wdata_i);
            end
        end
    end

    assign dac_data_a_o = data_a_q;
    assign dac_data_b_o = data_b_q;

endmodule

// ==== verilog/instr_top.sv ====
`include "instr_cfg.svh"

module instr_top
    import instr_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,

    // usb cdc byte interface
    input  instr_byte_t usb_data_i,
    input  logic        usb_valid_i,
    output instr_byte_t usb_upload_data_o,
    output logic        usb_upload_valid_o,

    // instrument pins
    output pwm_vec_t    pwm_o,
    output dac_code_t   dac_data_a_o,
    output dac_code_t   dac_data_b_o
);

    // parser to pwm bank
    logic      duty_we;
    pwm_ch_t   duty_ch;
    duty_t     duty_wdata;
    pwm_ch_t   rd_ch;
    duty_t     rd_duty;

    // parser to dac driver
    logic      dac_we_a;
    logic      dac_we_b;
    dac_code_t dac_wdata;

    // timebase to pwm bank
    duty_t     pwm_cnt;
    logic      pwm_wrap;

    // ============================================================
    // command side
    // ============================================================
    cmd_parser_fsm u_cmd_parser_fsm (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .usb_data_i         (usb_data_i),
        .usb_valid_i        (usb_valid_i),
        .duty_we_o          (duty_we),
        .duty_ch_o          (duty_ch),
        .duty_wdata_o       (duty_wdata),
        .rd_ch_o            (rd_ch),
        .rd_duty_i          (rd_duty),
        .dac_we_a_o         (dac_we_a),
        .dac_we_b_o         (dac_we_b),
        .dac_wdata_o        (dac_wdata),
        .usb_upload_data_o  (usb_upload_data_o),
        .usb_upload_valid_o (usb_upload_valid_o)
    );

    // ============================================================
    // outputs
    // ============================================================
    pwm_timebase u_pwm_timebase (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .pwm_cnt_o  (pwm_cnt),
        .pwm_wrap_o (pwm_wrap)
    );

    pwm_bank u_pwm_bank (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .duty_we_i    (duty_we),
        .duty_ch_i    (duty_ch),
        .duty_wdata_i (duty_wdata),
        .rd_ch_i      (rd_ch),
        .pwm_cnt_i    (pwm_cnt),
        .pwm_wrap_i   (pwm_wrap),
        .pwm_o        (pwm_o),
        .rd_duty_o    (rd_duty)
    );

    dac_driver u_dac_driver (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .dac_we_a_i   (dac_we_a),
        .dac_we_b_i   (dac_we_b),
        .dac_wdata_i  (dac_wdata),
        .dac_data_a_o (dac_data_a_o),
        .dac_data_b_o (dac_data_b_o)
    );

endmodule

// ==== verification/instr_sva.sv ====
`include "instr_cfg.svh"

module instr_sva
    import instr_pkg::*;
(
    input logic      clk_i,
    input logic      arst_n_i,
    input logic      usb_valid_i,
    input logic      usb_upload_valid_o,
    input pwm_vec_t  pwm_o,
    input dac_code_t dac_data_a_o,
    input dac_code_t dac_data_b_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam dac_code_t MIDSCALE = 14'h2000;

    // ============================================================
    // reply burst and reset values
    // ============================================================
    reply_len_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(usb_upload_valid_o) |-> usb_upload_valid_o [*3] ##1 !usb_upload_valid_o)
        else $error("upload strobe run is not three cycles long");

    reset_dac_a: assert property (@(posedge clk_i)
        !arst_n_i |-> (dac_data_a_o == MIDSCALE) && (dac_data_b_o == MIDSCALE))
        else $error("dac outputs not at midscale during reset");

    reset_pwm_a: assert property (@(posedge clk_i) !arst_n_i |-> (pwm_o == '0))
        else $error("pwm pins not low during reset");

    // ============================================================
    // dac outputs move only after a frame
    // ============================================================
    // new code shows up two edges after the last byte
    dac_a_change_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $changed(dac_data_a_o) |-> $past(usb_valid_i, 3))
        else $error("dac channel a changed without a preceding byte");

    dac_b_change_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $changed(dac_data_b_o) |-> $past(usb_valid_i, 3))
        else $error("dac channel b changed without a preceding byte");

endmodule

bind instr_top instr_sva instr_sva_i (.*);

// ==== verification/instr_tb.sv ====
`include "instr_cfg.svh"

module instr_tb
    import instr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int        CLK_PERIOD     = 20;
    // twelve pwm periods plus frame overhead
    localparam int        TIMEOUT_CYCLES = 12 * 256 + 200;
    localparam dac_code_t MIDSCALE       = 14'h2000;

    logic        clk_i;
    logic        arst_n_i;
    instr_byte_t usb_data_i;
    logic        usb_valid_i;
    instr_byte_t usb_upload_data_o;
    logic        usb_upload_valid_o;
    pwm_vec_t    pwm_o;
    dac_code_t   dac_data_a_o;
    dac_code_t   dac_data_b_o;

    integer      seed;
    int          error_count;
    int          cycle_count;

    // reference model of the instrument state
    duty_t       exp_duty [`INSTR_PWM_CH];
    dac_code_t   exp_dac_a;
    dac_code_t   exp_dac_b;

    instr_top instr_top_i (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .usb_data_i         (usb_data_i),
        .usb_valid_i        (usb_valid_i),
        .usb_upload_data_o  (usb_upload_data_o),
        .usb_upload_valid_o (usb_upload_valid_o),
        .pwm_o              (pwm_o),
        .dac_data_a_o       (dac_data_a_o),
        .dac_data_b_o       (dac_data_b_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ============================================================
    // compare tasks
    // ============================================================
    task automatic check_byte(input string name, input instr_byte_t exp, input instr_byte_t act);
        if (act !== exp) begin
            error_count++;
            $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_dac(input string name, input dac_code_t exp, input dac_code_t act);
        if (act !== exp) begin
            error_count++;
            $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_pwm(input string name, input pwm_vec_t exp, input pwm_vec_t act);
        if (act !== exp) begin
            error_count++;
            $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_duty(input string name, input duty_t exp, input duty_t act);
        if (act !== exp) begin
            error_count++;
            $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic send_byte(input instr_byte_t data);
        usb_data_i  = data;
        usb_valid_i = 1'b1;
        next_cycle();
        usb_valid_i = 1'b0;
    endtask

    task automatic send_frame(input instr_byte_t opcode, input instr_byte_t index,
                              input instr_byte_t data_hi, input instr_byte_t data_lo);
        send_byte(`INSTR_SYNC_BYTE);
        send_byte(opcode);
        send_byte(index);
        send_byte(data_hi);
        send_byte(data_lo);
    endtask

    // reply must start two edges after the last byte
    task automatic expect_reply(input instr_byte_t index, input duty_t duty);
        int wait_cycles;
        wait_cycles = 0;
        while (!usb_upload_valid_o && wait_cycles < 8) begin
            next_cycle();
            wait_cycles++;
        end
        if (!usb_upload_valid_o) begin
            error_count++;
            $display("no reply strobe after reading channel %0d", index);
        end else begin
            if (wait_cycles != 2) begin
                error_count++;
                $display("reply for channel %0d began after %0d cycles instead of 2",
                         index, wait_cycles);
            end
            check_byte("usb_upload_data_o header", `INSTR_REPLY_BYTE, usb_upload_data_o);
            next_cycle();
            if (usb_upload_valid_o !== 1'b1) begin
                error_count++;
                $display("upload strobe dropped before the index byte");
            end
            check_byte("usb_upload_data_o index", index, usb_upload_data_o);
            next_cycle();
            if (usb_upload_valid_o !== 1'b1) begin
                error_count++;
                $display("upload strobe dropped before the duty byte");
            end
            check_byte("usb_upload_data_o duty", duty, usb_upload_data_o);
            next_cycle();
            if (usb_upload_valid_o !== 1'b0) begin
                error_count++;
                $display("upload strobe still high after three reply bytes");
            end
        end
    endtask

    // offset binary is the signed code with its msb flipped
    task automatic write_dac(input instr_byte_t index, input dac_code_t code);
        send_frame(`INSTR_OP_SET_DAC, index, {2'b00, code[13:8]}, code[7:0]);
        next_cycle();
        check_dac("dac_data_a_o one cycle early", exp_dac_a, dac_data_a_o);
        check_dac("dac_data_b_o one cycle early", exp_dac_b, dac_data_b_o);
        next_cycle();
        if (index == 0) begin
            exp_dac_a = code ^ MIDSCALE;
        end else begin
            exp_dac_b = code ^ MIDSCALE;
        end
        check_dac("dac_data_a_o", exp_dac_a, dac_data_a_o);
        check_dac("dac_data_b_o", exp_dac_b, dac_data_b_o);
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic test_reset_state();
        check_dac("dac_data_a_o after reset", MIDSCALE, dac_data_a_o);
        check_dac("dac_data_b_o after reset", MIDSCALE, dac_data_b_o);
        repeat (300) begin
            check_pwm("pwm_o after reset", '0, pwm_o);
            if (usb_upload_valid_o !== 1'b0) begin
                error_count++;
                $display("upload strobe seen without any request");
            end
            next_cycle();
        end
    endtask

    task automatic test_dac_write();
        repeat (2) begin
            write_dac(8'd0, dac_code_t'($random(seed)));
            write_dac(8'd1, dac_code_t'($random(seed)));
        end
    endtask

    task automatic test_pwm_duty();
        int    high_cnt [`INSTR_PWM_CH];
        duty_t duty;
        for (int ch = 0; ch < `INSTR_PWM_CH; ch++) begin
            if (ch == 0) begin
                duty = 8'h00;
            end else if (ch == 1) begin
                duty = 8'hFF;
            end else begin
                duty = duty_t'($random(seed));
            end
            send_frame(`INSTR_OP_SET_DUTY, instr_byte_t'(ch), 8'h00, duty);
            next_cycle();
            exp_duty[ch] = duty;
        end
        // a wrap has to pass before the new duties apply
        repeat (270) next_cycle();
        for (int i = 0; i < `INSTR_PWM_CH; i++) begin
            high_cnt[i] = 0;
        end
        repeat (256) begin
            for (int i = 0; i < `INSTR_PWM_CH; i++) begin
                high_cnt[i] += pwm_o[i];
            end
            next_cycle();
        end
        for (int i = 0; i < `INSTR_PWM_CH; i++) begin
            if (high_cnt[i] > 255) begin
                error_count++;
                $display("pwm_o[%0d] never went low over a whole period", i);
            end else begin
                check_duty($sformatf("high cycles of pwm_o[%0d]", i), exp_duty[i],
                           duty_t'(high_cnt[i]));
            end
        end
    endtask

    task automatic test_read_back();
        for (int ch = 0; ch < `INSTR_PWM_CH; ch++) begin
            send_frame(`INSTR_OP_READ_DUTY, instr_byte_t'(ch), 8'h00, 8'h00);
            expect_reply(instr_byte_t'(ch), exp_duty[ch]);
        end
    endtask

    task automatic test_invalid_input();
        // stray bytes while idle
        send_byte(8'h00);
        send_byte(8'hAA);
        send_byte(8'h03);
        send_byte(8'h5A);
        send_frame(8'h7E, 8'h01, 8'h00, 8'h42);
        next_cycle();
        send_frame(`INSTR_OP_SET_DUTY, 8'd8, 8'h00, 8'hA5);
        next_cycle();
        send_frame(`INSTR_OP_SET_DAC, 8'd2, 8'h15, 8'h5A);
        next_cycle();
        send_frame(`INSTR_OP_READ_DUTY, 8'd8, 8'h00, 8'h00);
        repeat (6) begin
            if (usb_upload_valid_o !== 1'b0) begin
                error_count++;
                $display("reply sent for an out of range channel");
            end
            next_cycle();
        end
        check_dac("dac_data_a_o after invalid frames", exp_dac_a, dac_data_a_o);
        check_dac("dac_data_b_o after invalid frames", exp_dac_b, dac_data_b_o);
        repeat (270) next_cycle();
        test_read_back();
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        seed        = 32'h4991_2c96;
        error_count = 0;
        arst_n_i    = 1'b1;
        usb_data_i  = '0;
        usb_valid_i = 1'b0;
        exp_dac_a   = MIDSCALE;
        exp_dac_b   = MIDSCALE;
        for (int i = 0; i < `INSTR_PWM_CH; i++) begin
            exp_duty[i] = '0;
        end
        #1 arst_n_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #2 arst_n_i = 1'b1;

        test_reset_state();
        test_dac_write();
        test_pwm_duty();
        test_read_back();
        test_invalid_input();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
common/instr_pkg.sv
cmd_parser/cmd_parser_fsm.sv
verilog/pwm_timebase.sv
verilog/pwm_bank.sv
verilog/dac_driver.sv
verilog/instr_top.sv
verification/instr_sva.sv
verification/instr_tb.sv

// ==== Bender.yml ====
package:
  name: instr_top

sources:
  - include_dirs:
      - common
    files:
      - common/instr_pkg.sv
      - cmd_parser/cmd_parser_fsm.sv
      - verilog/pwm_timebase.sv
      - verilog/pwm_bank.sv
      - verilog/dac_driver.sv
      - verilog/instr_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/instr_sva.sv
      - verification/instr_tb.sv
